//--- verilog/dcache_pkg.sv
// data cache shared types

package dcache_pkg;

  // geometry
  localparam int num_ways = 4;
  localparam int num_sets = 16;

  // byte address split, tag | set | offset
  localparam int offset_bits = 3;
  localparam int index_bits = 4;
  localparam int tag_bits = 25;

  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [tag_bits-1:0] tag_t;
  typedef logic [index_bits-1:0] set_idx_t;
  typedef logic [num_ways-1:0] way_mask_t;

  typedef struct packed {
    tag_t                   tag;
    set_idx_t               set_index;
    logic [offset_bits-1:0] offset;
  } dcache_addr_t;

  // one stored line
  typedef struct packed {
    logic  valid;
    logic  dirty;
    tag_t  tag;
    data_t data;
  } cache_line_t;

  // single write port into the array
  typedef struct packed {
    logic         en;
    // refill or allocate, not a hit update
    logic         from_mem;
    dcache_addr_t addr;
    data_t        data;
    logic         dirty;
  } line_wr_t;

  // eviction candidate, addr is line aligned
  typedef struct packed {
    logic  valid;
    logic  dirty;
    addr_t addr;
    data_t data;
  } victim_t;

  typedef enum logic [2:0] {
    idle,
    lookup,
    wb_evict,
    refill,
    respond
  } ctrl_state_t;

endpackage

//--- verilog/cache_bank.sv
// cache way storage

`timescale 1ns/10ps

module cache_bank (
  input  logic                      clock,
  input  logic                      reset,
  input  dcache_pkg::dcache_addr_t  lookup_addr,
  input  dcache_pkg::line_wr_t      wr,
  input  logic                      way_we,
  output logic                      hit,
  output dcache_pkg::data_t         line_data,
  output dcache_pkg::victim_t       victim
);

  dcache_pkg::cache_line_t lines [dcache_pkg::num_sets];
  dcache_pkg::cache_line_t cur_line;

  // set selected by the current lookup
  assign cur_line = lines[lookup_addr.set_index];

  assign hit = cur_line.valid && (cur_line.tag == lookup_addr.tag);
  assign line_data = cur_line.data;

  // whatever sits in the set is the eviction candidate
  assign victim.valid = cur_line.valid;
  assign victim.dirty = cur_line.dirty;
  assign victim.addr = {cur_line.tag, lookup_addr.set_index,
                        {dcache_pkg::offset_bits{1'b0}}};
  assign victim.data = cur_line.data;

  // tag and data keep their contents through reset
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < dcache_pkg::num_sets; i++) begin
        lines[i].valid <= 1'b0;
        lines[i].dirty <= 1'b0;
      end
    end else if (way_we) begin
      lines[wr.addr.set_index] <= '{
        valid: 1'b1,
        dirty: wr.dirty,
        tag:   wr.addr.tag,
        data:  wr.data
      };
    end
  end

  // controller hands over line aligned addresses only
  offset_aligned_a: assert property (
    @(posedge clock) disable iff (reset)
    way_we |-> (wr.addr.offset == '0)
  ) else $error("cache_bank: write with nonzero offset");

endmodule

//--- verilog/plru_tree.sv
// tree pseudo lru

`timescale 1ns/10ps

module plru_tree (
  input  logic                    clock,
  input  logic                    reset,
  input  dcache_pkg::set_idx_t    set_index,
  input  logic                    access,
  input  dcache_pkg::way_mask_t   access_way,
  output dcache_pkg::way_mask_t   victim_way
);

  // root picks a half, lo covers ways 0/1, hi covers ways 2/3
  logic [dcache_pkg::num_sets-1:0] root_bit;
  logic [dcache_pkg::num_sets-1:0] lo_bit;
  logic [dcache_pkg::num_sets-1:0] hi_bit;
  logic root_sel;
  logic half_sel;
  logic in_lo_half;

  assign root_sel = root_bit[set_index];
  assign half_sel = root_sel ? hi_bit[set_index] : lo_bit[set_index];

  // {root, half} is the way number
  always_comb begin
    victim_way = '0;
    victim_way[{root_sel, half_sel}] = 1'b1;
  end

  assign in_lo_half = access_way[0] | access_way[1];

  // point both levels away from the way just used
  always_ff @(posedge clock) begin
    if (reset) begin
      root_bit <= '0;
      lo_bit <= '0;
      hi_bit <= '0;
    end else if (access) begin
      if (in_lo_half) begin
        root_bit[set_index] <= 1'b1;
        lo_bit[set_index] <= access_way[0];
      end else begin
        root_bit[set_index] <= 1'b0;
        hi_bit[set_index] <= access_way[2];
      end
    end
  end

  access_onehot_a: assert property (
    @(posedge clock) disable iff (reset)
    access |-> $onehot(access_way)
  ) else $error("plru_tree: access way not one-hot");

endmodule

//--- verilog/dcache_array.sv
// four way cache array

`timescale 1ns/10ps

module dcache_array (
  input  logic                      clock,
  input  logic                      reset,
  input  dcache_pkg::dcache_addr_t  lookup_addr,
  input  dcache_pkg::line_wr_t      wr,
  input  logic                      touch,
  output logic                      hit,
  output dcache_pkg::data_t         hit_data,
  output dcache_pkg::victim_t       victim
);

  dcache_pkg::way_mask_t bank_hit;
  dcache_pkg::way_mask_t lru_way;
  dcache_pkg::way_mask_t sel_way;
  dcache_pkg::way_mask_t way_we;
  dcache_pkg::data_t     bank_data [dcache_pkg::num_ways];
  dcache_pkg::victim_t   bank_victim [dcache_pkg::num_ways];
  dcache_pkg::set_idx_t  lru_set;
  logic                  lru_access;

  for (genvar w = 0; w < dcache_pkg::num_ways; w++) begin : g_way
    cache_bank bank_i (
      .clock       (clock),
      .reset       (reset),
      .lookup_addr (lookup_addr),
      .wr          (wr),
      .way_we      (way_we[w]),
      .hit         (bank_hit[w]),
      .line_data   (bank_data[w]),
      .victim      (bank_victim[w])
    );
  end

  assign hit = |bank_hit;

  // hitting way on a hit, otherwise the lru choice
  assign sel_way = hit ? bank_hit : lru_way;

  // a miss write only lands when it comes from memory
  always_comb begin
    way_we = '0;
    if (wr.en && (hit || wr.from_mem)) begin
      way_we = sel_way;
    end
  end

  always_comb begin
    hit_data = '0;
    victim = '0;
    for (int i = 0; i < dcache_pkg::num_ways; i++) begin
      if (bank_hit[i]) begin
        hit_data = bank_data[i];
      end
      if (sel_way[i]) begin
        victim = bank_victim[i];
      end
    end
  end

  // every write and every touched read hit counts as a use
  assign lru_access = (wr.en && (hit || wr.from_mem)) || (touch && hit);
  assign lru_set = wr.en ? wr.addr.set_index : lookup_addr.set_index;

  plru_tree plru_i (
    .clock      (clock),
    .reset      (reset),
    .set_index  (lru_set),
    .access     (lru_access),
    .access_way (sel_way),
    .victim_way (lru_way)
  );

  // a tag lives in one way only
  single_hit_a: assert property (
    @(posedge clock) disable iff (reset)
    $onehot0(bank_hit)
  ) else $error("dcache_array: tag present in more than one way");

endmodule

//--- verilog/dcache_ctrl.sv
// write back cache controller

`timescale 1ns/10ps

module dcache_ctrl (
  input  logic                      clock,
  input  logic                      reset,
  // processor side
  input  logic                      cpu_cyc,
  input  logic                      cpu_stb,
  input  logic                      cpu_we,
  input  dcache_pkg::addr_t         cpu_adr,
  input  dcache_pkg::data_t         cpu_dat_w,
  output dcache_pkg::data_t         cpu_dat_r,
  output logic                      cpu_ack,
  // memory side
  output logic                      mem_cyc,
  output logic                      mem_stb,
  output logic                      mem_we,
  output dcache_pkg::addr_t         mem_adr,
  output dcache_pkg::data_t         mem_dat_w,
  input  dcache_pkg::data_t         mem_dat_r,
  input  logic                      mem_ack,
  // array side
  output dcache_pkg::dcache_addr_t  lookup_addr,
  output dcache_pkg::line_wr_t      wr,
  output logic                      touch,
  input  logic                      hit,
  input  dcache_pkg::data_t         hit_data,
  input  dcache_pkg::victim_t       victim
);

  dcache_pkg::ctrl_state_t  state;
  dcache_pkg::ctrl_state_t  next_state;
  dcache_pkg::dcache_addr_t req_addr;
  logic                     req_we;
  dcache_pkg::data_t        req_data;
  dcache_pkg::data_t        resp_data;
  dcache_pkg::victim_t      vic_q;
  logic                     vic_dirty;
  logic                     cpu_req;

  assign cpu_req = cpu_cyc && cpu_stb;
  assign vic_dirty = victim.valid && victim.dirty;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= dcache_pkg::idle;
    end else begin
      state <= next_state;
    end
  end

  // request, victim and read data holding
  always_ff @(posedge clock) begin
    if (state == dcache_pkg::idle && cpu_req) begin
      // whole word accesses, drop the byte offset
      req_addr <= {cpu_adr[31:dcache_pkg::offset_bits], {dcache_pkg::offset_bits{1'b0}}};
      req_we <= cpu_we;
      req_data <= cpu_dat_w;
    end
    if (state == dcache_pkg::lookup && !hit) begin
      vic_q <= victim;
    end
    if (state == dcache_pkg::lookup && hit && !req_we) begin
      resp_data <= hit_data;
    end
    if (state == dcache_pkg::refill && mem_ack) begin
      resp_data <= mem_dat_r;
    end
  end

  always_comb begin
    next_state = state;
    wr = '0;
    wr.addr = req_addr;
    wr.data = req_data;
    touch = 1'b0;
    unique case (state)
      dcache_pkg::idle: begin
        if (cpu_req) begin
          next_state = dcache_pkg::lookup;
        end
      end
      dcache_pkg::lookup: begin
        if (hit) begin
          next_state = dcache_pkg::respond;
          if (req_we) begin
            wr.en = 1'b1;
            wr.dirty = 1'b1;
          end else begin
            touch = 1'b1;
          end
        end else if (vic_dirty) begin
          next_state = dcache_pkg::wb_evict;
        end else if (!req_we) begin
          next_state = dcache_pkg::refill;
        end else begin
          // write miss over a clean way, allocate straight away
          wr.en = 1'b1;
          wr.from_mem = 1'b1;
          wr.dirty = 1'b1;
          next_state = dcache_pkg::respond;
        end
      end
      dcache_pkg::wb_evict: begin
        if (mem_ack) begin
          if (req_we) begin
            wr.en = 1'b1;
            wr.from_mem = 1'b1;
            wr.dirty = 1'b1;
            next_state = dcache_pkg::respond;
          end else begin
            next_state = dcache_pkg::refill;
          end
        end
      end
      dcache_pkg::refill: begin
        if (mem_ack) begin
          wr.en = 1'b1;
          wr.from_mem = 1'b1;
          wr.data = mem_dat_r;
          next_state = dcache_pkg::respond;
        end
      end
      dcache_pkg::respond: begin
        next_state = dcache_pkg::idle;
      end
      default: begin
        next_state = dcache_pkg::idle;
      end
    endcase
  end

  // memory request follows the state, so it stays put until ack
  assign mem_cyc = (state == dcache_pkg::wb_evict) || (state == dcache_pkg::refill);
  assign mem_stb = mem_cyc;
  assign mem_we = (state == dcache_pkg::wb_evict);
  assign mem_adr = (state == dcache_pkg::wb_evict) ? vic_q.addr : dcache_pkg::addr_t'(req_addr);
  assign mem_dat_w = vic_q.data;

  assign cpu_ack = (state == dcache_pkg::respond);
  assign cpu_dat_r = resp_data;
  assign lookup_addr = req_addr;

  no_mem_stb_a: assert property (
    @(posedge clock) disable iff (reset)
    (state == dcache_pkg::idle || state == dcache_pkg::respond) |-> !mem_stb
  ) else $error("dcache_ctrl: memory strobe outside a memory state");

endmodule

//--- verilog/dcache_top.sv
// data cache top level

`timescale 1ns/10ps

module dcache_top (
  input  logic               clock,
  input  logic               reset,
  // processor wishbone slave
  input  logic               cpu_cyc,
  input  logic               cpu_stb,
  input  logic               cpu_we,
  input  dcache_pkg::addr_t  cpu_adr,
  input  dcache_pkg::data_t  cpu_dat_w,
  output dcache_pkg::data_t  cpu_dat_r,
  output logic               cpu_ack,
  // memory wishbone master
  output logic               mem_cyc,
  output logic               mem_stb,
  output logic               mem_we,
  output dcache_pkg::addr_t  mem_adr,
  output dcache_pkg::data_t  mem_dat_w,
  input  dcache_pkg::data_t  mem_dat_r,
  input  logic               mem_ack
);

  dcache_pkg::dcache_addr_t lookup_addr;
  dcache_pkg::line_wr_t     wr;
  dcache_pkg::data_t        hit_data;
  dcache_pkg::victim_t      victim;
  logic                     touch;
  logic                     hit;

  dcache_ctrl ctrl_i (
    .clock       (clock),
    .reset       (reset),
    .cpu_cyc     (cpu_cyc),
    .cpu_stb     (cpu_stb),
    .cpu_we      (cpu_we),
    .cpu_adr     (cpu_adr),
    .cpu_dat_w   (cpu_dat_w),
    .cpu_dat_r   (cpu_dat_r),
    .cpu_ack     (cpu_ack),
    .mem_cyc     (mem_cyc),
    .mem_stb     (mem_stb),
    .mem_we      (mem_we),
    .mem_adr     (mem_adr),
    .mem_dat_w   (mem_dat_w),
    .mem_dat_r   (mem_dat_r),
    .mem_ack     (mem_ack),
    .lookup_addr (lookup_addr),
    .wr          (wr),
    .touch       (touch),
    .hit         (hit),
    .hit_data    (hit_data),
    .victim      (victim)
  );

  dcache_array array_i (
    .clock       (clock),
    .reset       (reset),
    .lookup_addr (lookup_addr),
    .wr          (wr),
    .touch       (touch),
    .hit         (hit),
    .hit_data    (hit_data),
    .victim      (victim)
  );

endmodule

//--- tb/wb_mem_model.sv
// wishbone memory model

`timescale 1ns/10ps

module wb_mem_model (
  input  logic              clock,
  input  logic              reset,
  input  logic              mem_cyc,
  input  logic              mem_stb,
  input  logic              mem_we,
  input  dcache_pkg::addr_t mem_adr,
  input  dcache_pkg::data_t mem_dat_w,
  output dcache_pkg::data_t mem_dat_r,
  output logic              mem_ack,
  output int                read_count,
  output int                write_count,
  output dcache_pkg::addr_t last_wr_adr,
  output dcache_pkg::data_t last_wr_dat,
  output logic              last_op_we
);

  // only written lines are stored
  dcache_pkg::data_t mem [dcache_pkg::addr_t];
  logic wait_done;

  // ack after two cycles of a held request, low again right after
  always @(posedge clock) begin
    if (reset) begin
      mem_ack <= 1'b0;
      wait_done <= 1'b0;
      mem_dat_r <= '0;
      read_count <= 0;
      write_count <= 0;
      last_wr_adr <= '0;
      last_wr_dat <= '0;
      last_op_we <= 1'b0;
    end else if (mem_ack || !(mem_cyc && mem_stb)) begin
      mem_ack <= 1'b0;
      wait_done <= 1'b0;
    end else if (!wait_done) begin
      wait_done <= 1'b1;
    end else begin
      mem_ack <= 1'b1;
      last_op_we <= mem_we;
      if (mem_we) begin
        mem[mem_adr] = mem_dat_w;
        write_count <= write_count + 1;
        last_wr_adr <= mem_adr;
        last_wr_dat <= mem_dat_w;
        $display("mem write %h <= %h", mem_adr, mem_dat_w);
      end else begin
        // never written, so the address twice
        read_count <= read_count + 1;
        mem_dat_r <= mem.exists(mem_adr) ? mem[mem_adr] : {mem_adr, mem_adr};
      end
    end
  end

endmodule

//--- tb/dcache_tb.sv
// data cache testbench

`timescale 1ns/10ps

module dcache_tb;

  logic clock;
  logic reset;
  logic cpu_cyc;
  logic cpu_stb;
  logic cpu_we;
  dcache_pkg::addr_t cpu_adr;
  dcache_pkg::data_t cpu_dat_w;
  dcache_pkg::data_t cpu_dat_r;
  logic cpu_ack;
  logic mem_cyc;
  logic mem_stb;
  logic mem_we;
  dcache_pkg::addr_t mem_adr;
  dcache_pkg::data_t mem_dat_w;
  dcache_pkg::data_t mem_dat_r;
  logic mem_ack;
  int read_count;
  int write_count;
  dcache_pkg::addr_t last_wr_adr;
  dcache_pkg::data_t last_wr_dat;
  logic last_op_we;
  int checks;
  int errors;
  logic [15:0] lfsr_state;
  // expected memory plus cache contents
  dcache_pkg::data_t scoreboard [dcache_pkg::addr_t];

  dcache_top dcache_top_i (.*);
  wb_mem_model mem_model_i (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic dcache_pkg::data_t take_bits(input int n);
    dcache_pkg::data_t bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[62:0], lfsr_state[15]};
      lfsr_state = {lfsr_state[14:0],
                    lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
    end
    return bits;
  endfunction

  // untouched memory reads back its address twice
  function automatic dcache_pkg::data_t expected_data(input dcache_pkg::addr_t adr);
    if (scoreboard.exists(adr)) begin
      return scoreboard[adr];
    end
    return {adr, adr};
  endfunction

  function automatic dcache_pkg::addr_t line_addr(input dcache_pkg::tag_t tag,
                                                  input dcache_pkg::set_idx_t set_index);
    return {tag, set_index, {dcache_pkg::offset_bits{1'b0}}};
  endfunction

  task automatic check_value(input string test, input string what,
                             input dcache_pkg::data_t expected,
                             input dcache_pkg::data_t actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAIL %s %s: expected %0h, actual %0h", test, what, expected, actual);
    end
  endtask

  // both buses quiet while reset is held
  task automatic verify_reset_state();
    check_value("reset", "cpu_ack", 64'd0, 64'(cpu_ack));
    check_value("reset", "mem_cyc", 64'd0, 64'(mem_cyc));
    check_value("reset", "mem_stb", 64'd0, 64'(mem_stb));
    check_value("reset", "mem_we", 64'd0, 64'(mem_we));
  endtask

  // one processor request, latency counted from the edge that samples it
  task automatic cpu_access(input string test, input logic we, input dcache_pkg::addr_t adr,
                            input dcache_pkg::data_t wdata, output int latency);
    dcache_pkg::data_t rdata;
    int cycles;
    @(posedge clock);
    cpu_cyc <= 1'b1;
    cpu_stb <= 1'b1;
    cpu_we <= we;
    cpu_adr <= adr;
    cpu_dat_w <= wdata;
    cycles = 0;
    do begin
      @(posedge clock);
      cycles++;
    end while (!cpu_ack && cycles < 200);
    assert (cpu_ack) else begin
      errors++;
      $display("%s: cpu_ack did not arrive within 200 cycles", test);
    end
    rdata = cpu_dat_r;
    cpu_cyc <= 1'b0;
    cpu_stb <= 1'b0;
    cpu_we <= 1'b0;
    latency = cycles - 1;
    if (we) begin
      scoreboard[adr] = wdata;
    end else begin
      check_value(test, "read data", expected_data(adr), rdata);
    end
  endtask

  // a writeback carries the newest data of its line
  always @(posedge clock) begin
    if (!reset && mem_stb && mem_we && mem_ack) begin
      check_value("writeback", "memory data", expected_data(mem_adr), mem_dat_w);
    end
  end

  task automatic cold_read_then_hit();
    dcache_pkg::addr_t a;
    int rd0;
    int wr0;
    int lat;
    a = line_addr(25'h123, 4'd1);
    rd0 = read_count;
    wr0 = write_count;
    cpu_access("cold_read", 1'b0, a, '0, lat);
    check_value("cold_read", "memory reads", 64'(rd0 + 1), 64'(read_count));
    cpu_access("cold_read", 1'b0, a, '0, lat);
    check_value("cold_read", "memory reads on hit", 64'(rd0 + 1), 64'(read_count));
    check_value("cold_read", "memory writes", 64'(wr0), 64'(write_count));
    check_value("cold_read", "hit latency", 64'd2, 64'(lat));
  endtask

  task automatic write_hit_readback();
    dcache_pkg::addr_t a;
    int wr0;
    int lat;
    a = line_addr(25'h123, 4'd1);
    wr0 = write_count;
    cpu_access("write_hit", 1'b1, a, take_bits(64), lat);
    check_value("write_hit", "write latency", 64'd2, 64'(lat));
    cpu_access("write_hit", 1'b0, a, '0, lat);
    check_value("write_hit", "memory writes", 64'(wr0), 64'(write_count));
  endtask

  // four tags fill the set, the fifth evicts the first one
  task automatic run_eviction(input string test, input dcache_pkg::set_idx_t set_index,
                              input dcache_pkg::tag_t base, input logic dirty_first);
    dcache_pkg::addr_t a;
    dcache_pkg::data_t first_data;
    int rd0;
    int wr0;
    int lat;
    a = line_addr(base, set_index);
    first_data = take_bits(64);
    cpu_access(test, dirty_first, a, first_data, lat);
    for (int i = 1; i < 4; i++) begin
      cpu_access(test, 1'b0, line_addr(base + dcache_pkg::tag_t'(i), set_index), '0, lat);
    end
    rd0 = read_count;
    wr0 = write_count;
    cpu_access(test, 1'b0, line_addr(base + 25'd4, set_index), '0, lat);
    check_value(test, "refill reads", 64'(rd0 + 1), 64'(read_count));
    if (dirty_first) begin
      check_value(test, "writebacks", 64'(wr0 + 1), 64'(write_count));
      check_value(test, "writeback address", 64'(a), 64'(last_wr_adr));
      check_value(test, "writeback data", first_data, last_wr_dat);
      check_value(test, "refill after writeback", 64'd0, 64'(last_op_we));
    end else begin
      check_value(test, "writebacks", 64'(wr0), 64'(write_count));
    end
  endtask

  task automatic write_miss_allocate();
    dcache_pkg::addr_t a;
    dcache_pkg::data_t wdata;
    int rd0;
    int wr0;
    int lat;
    a = line_addr(25'h300, 4'd7);
    wdata = take_bits(64);
    rd0 = read_count;
    wr0 = write_count;
    cpu_access("write_alloc", 1'b1, a, wdata, lat);
    cpu_access("write_alloc", 1'b0, a, '0, lat);
    check_value("write_alloc", "memory reads", 64'(rd0), 64'(read_count));
    for (int i = 1; i < 5; i++) begin
      cpu_access("write_alloc", 1'b0, line_addr(25'h300 + dcache_pkg::tag_t'(i), 4'd7), '0, lat);
    end
    check_value("write_alloc", "writebacks", 64'(wr0 + 1), 64'(write_count));
    check_value("write_alloc", "writeback address", 64'(a), 64'(last_wr_adr));
    check_value("write_alloc", "writeback data", wdata, last_wr_dat);
  endtask

  task automatic random_mix();
    dcache_pkg::data_t bits;
    int lat;
    for (int i = 0; i < 40; i++) begin
      bits = take_bits(6);
      // sets 12 to 15, eight tags each
      cpu_access("random_mix", bits[5], line_addr({22'h10, bits[4:2]}, {2'b11, bits[1:0]}),
                 take_bits(64), lat);
    end
  endtask

  initial begin
    checks = 0;
    errors = 0;
    lfsr_state = 16'd22717;
    reset = 1'b1;
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;
    cpu_we = 1'b0;
    cpu_adr = '0;
    cpu_dat_w = '0;
    repeat (16) @(posedge clock);
    verify_reset_state();
    reset <= 1'b0;
    cold_read_then_hit();
    write_hit_readback();
    run_eviction("dirty_evict", 4'd5, 25'h100, 1'b1);
    run_eviction("clean_evict", 4'd6, 25'h200, 1'b0);
    write_miss_allocate();
    random_mix();
    repeat (4) @(posedge clock);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
verilog/dcache_pkg.sv
verilog/cache_bank.sv
verilog/plru_tree.sv
verilog/dcache_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tb/wb_mem_model.sv
tb/dcache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the data cache testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f filelist.f --top-module dcache_tb -o dcache_sim &&
  ./obj_dir/dcache_sim | tee sim.log &&
  grep -q "^Testbench passed$" sim.log &&
  echo "simulation passed" ||
  { echo "simulation failed, see sim.log"; exit 1; }
